// ==== Makefile ====
# Verilator build and run of the ALU coprocessor testbench

VERILATOR ?= verilator
TOP       ?= tbAluCore
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMARGS   ?= +verilator+error+limit+1000

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(SIMARGS) > $(LOG) 2>&1; true
	@cat $(LOG)
	@grep -qxF ">>> PASS" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== aluCmdFifo.sv ====
`timescale 1ns/1ps

module aluCmdFifo
#(
    parameter int depth = aluPkg::fifoDepth
)
(
    input  logic          clk,
    input  logic          rstN,
    input  logic          pushValid,
    input  aluPkg::aluCmd pushData,
    output logic          full,
    input  logic          pop,
    output aluPkg::aluCmd popData,
    output logic          empty
);
    import aluPkg::*;

    localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntW = $clog2(depth + 1);

    aluCmd            mem [depth];
    logic [ptrW-1:0]  wrPtr;
    logic [ptrW-1:0]  rdPtr;
    logic [cntW-1:0]  count;
    logic             doPush;
    logic             doPop;

    assign full    = (count == cntW'(depth));
    assign empty   = (count == '0);
    assign doPush  = pushValid && !full;
    assign doPop   = pop && !empty;
    assign popData = mem[rdPtr];                        // Oldest entry

    always_ff @(posedge clk)
    begin
        if (doPush)
        begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (doPush)
            begin
                wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;   // Wrap for any depth
            end
            if (doPop)
            begin
                rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                // Both or neither
            endcase
        end
    end

endmodule

// ==== aluCmdIntake.sv ====
`timescale 1ns/1ps

module aluCmdIntake
(
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         cmdCyc,
    input  logic                         cmdStb,
    input  logic                         cmdWe,
    input  logic [aluPkg::wbAddrW-1:0]   cmdAdr,
    input  logic [aluPkg::dataW-1:0]     cmdDatW,
    output logic [aluPkg::dataW-1:0]     cmdDatR,
    output logic                         cmdAck,
    input  aluPkg::statusFlags           flags,
    input  logic                         full,
    output logic                         pushValid,
    output aluPkg::aluCmd                pushData
);
    import aluPkg::*;

    logic [dataW-1:0] opAReg;
    logic [dataW-1:0] opBReg;
    logic             cmdReq;
    logic             cmdWrite;
    logic             accept;

    assign cmdReq   = cmdCyc && cmdStb && !cmdAck;      // Ignore the request while acking it
    assign cmdWrite = cmdReq && cmdWe && (cmdAdr == addrCmd);
    assign accept   = cmdReq && !(cmdWrite && full);    // Wait state on a full queue

    //////////////////////////////////////////////////////////////////////
    // Queue entry, opcode on top and immediate below
    assign pushValid = cmdWrite;
    assign pushData  = '{opcode: cmdDatW[dataW-1 -: opW],
                         imm:    cmdDatW[immW-1:0],
                         opA:    opAReg,
                         opB:    opBReg};

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            cmdAck <= 1'b0;
        end
        else
        begin
            cmdAck <= accept;                           // Single cycle pulse
        end
    end

    // Operand registers
    always_ff @(posedge clk)
    begin
        if (cmdReq && cmdWe && (cmdAdr == addrOpA))
        begin
            opAReg <= cmdDatW;
        end
        if (cmdReq && cmdWe && (cmdAdr == addrOpB))
        begin
            opBReg <= cmdDatW;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read path, valid together with cmdAck
    always_ff @(posedge clk)
    begin
        if (cmdReq && !cmdWe)
        begin
            case (cmdAdr)
                addrOpA:   cmdDatR <= opAReg;
                addrOpB:   cmdDatR <= opBReg;
                addrFlags: cmdDatR <= dataW'(flags);    // Zero extended
                default:   cmdDatR <= '0;               // Command reg is write only
            endcase
        end
    end

endmodule

// ==== aluCore.sv ====
`timescale 1ns/1ps

module aluCore
(
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       cmdCyc,
    input  logic                       cmdStb,
    input  logic                       cmdWe,
    input  logic [aluPkg::wbAddrW-1:0] cmdAdr,
    input  logic [aluPkg::dataW-1:0]   cmdDatW,
    output logic [aluPkg::dataW-1:0]   cmdDatR,
    output logic                       cmdAck,
    output logic                       resCyc,
    output logic                       resStb,
    output logic                       resWe,
    output logic [aluPkg::dataW-1:0]   resDat,
    output aluPkg::statusFlags         resFlags,
    input  logic                       resAck
);
    import aluPkg::*;

    statusFlags flags;
    logic       full;
    logic       empty;
    logic       pushValid;
    logic       pop;
    aluCmd      pushData;
    aluCmd      popData;

    //////////////////////////////////////////////////////////////////////
    // Host side
    aluCmdIntake intake
    (
        .clk       (clk),
        .rstN      (rstN),
        .cmdCyc    (cmdCyc),
        .cmdStb    (cmdStb),
        .cmdWe     (cmdWe),
        .cmdAdr    (cmdAdr),
        .cmdDatW   (cmdDatW),
        .cmdDatR   (cmdDatR),
        .cmdAck    (cmdAck),
        .flags     (flags),
        .full      (full),
        .pushValid (pushValid),
        .pushData  (pushData)
    );

    aluCmdFifo #(.depth(fifoDepth)) cmdQueue
    (
        .clk       (clk),
        .rstN      (rstN),
        .pushValid (pushValid),
        .pushData  (pushData),
        .full      (full),
        .pop       (pop),
        .popData   (popData),
        .empty     (empty)
    );

    aluExecute execute
    (
        .clk       (clk),
        .rstN      (rstN),
        .empty     (empty),
        .popData   (popData),
        .pop       (pop),
        .flags     (flags),               // Status back to the read path
        .resCyc    (resCyc),
        .resStb    (resStb),
        .resWe     (resWe),
        .resDat    (resDat),
        .resFlags  (resFlags),
        .resAck    (resAck)
    );

endmodule

// ==== aluExecute.sv ====
`timescale 1ns/1ps

module aluExecute
(
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     empty,
    input  aluPkg::aluCmd            popData,
    output logic                     pop,
    output aluPkg::statusFlags       flags,
    output logic                     resCyc,
    output logic                     resStb,
    output logic                     resWe,
    output logic [aluPkg::dataW-1:0] resDat,
    output aluPkg::statusFlags       resFlags,
    input  logic                     resAck
);
    import aluPkg::*;

    logic [opW-1:0]   op;
    logic [dataW-1:0] immExt;
    logic [dataW-1:0] operandB;
    logic             cin;
    logic [dataW:0]   sum;
    logic [dataW:0]   diff;
    logic [dataW-1:0] nextDat;
    statusFlags       nextFlags;
    logic             keep;
    logic             resBusy;

    assign op       = popData.opcode;
    assign immExt   = {{(dataW - immW){1'b0}}, popData.imm};
    assign operandB = (op == opAddIm || op == opSubIm) ? immExt : popData.opB;
    assign cin      = (op == opAddC || op == opSubC) ? flags[flagCarry] : 1'b0;
    assign sum      = {1'b0, popData.opA} + {1'b0, operandB} + {{dataW{1'b0}}, cin};
    assign diff     = {1'b0, popData.opA} - {1'b0, operandB} - {{dataW{1'b0}}, cin};

    //////////////////////////////////////////////////////////////////////
    // Result and flag computation for the head entry
    always_comb
    begin
        nextDat   = '0;
        nextFlags = flags;
        keep      = 1'b1;
        case (op)
            opAddIm, opAdd, opAddC:
            begin
                nextDat              = sum[dataW-1:0];
                nextFlags[flagCarry] = sum[dataW];
            end
            opSubIm, opSub, opSubC:
            begin
                nextDat              = diff[dataW-1:0];
                nextFlags[flagCarry] = diff[dataW];     // Borrow
            end
            opShl:  nextDat = popData.opA << popData.imm;   // 32 or more clears
            opShr:  nextDat = popData.opA >> popData.imm;
            opAnd:  nextDat = popData.opA & popData.opB;
            opNand: nextDat = ~(popData.opA & popData.opB);
            opOr:   nextDat = popData.opA | popData.opB;
            opNor:  nextDat = ~(popData.opA | popData.opB);
            opXor:  nextDat = popData.opA ^ popData.opB;
            opXnor: nextDat = ~(popData.opA ^ popData.opB);
            opCp:
            begin
                nextFlags[flagCmpHi] = (popData.opA >= popData.opB);    // 11 eq, 10 gt, 01 lt
                nextFlags[flagCmpLo] = (popData.opA <= popData.opB);
            end
            opSld:  nextDat = dataW'(flags);
            default:
            begin
                keep = 1'b0;                            // Dropped, no result
            end
        endcase
        if (keep && op != opCp && op != opSld)
        begin
            nextFlags[flagNeg] = nextDat[dataW-1];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Result handshake and status register
    assign pop      = !resBusy && !empty;
    assign resCyc   = resBusy;
    assign resStb   = resBusy;
    assign resWe    = resBusy;                          // Results are always writes
    assign resFlags = flags;                            // Frozen until the next pop

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            resBusy <= 1'b0;
            flags   <= '0;
        end
        else if (resBusy)
        begin
            if (resAck)
            begin
                resBusy <= 1'b0;                        // Idle for at least a cycle
            end
        end
        else if (!empty)
        begin
            resBusy <= keep;
            flags   <= nextFlags;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop && keep)
        begin
            resDat <= nextDat;
        end
    end

endmodule

// ==== aluPkg.sv ====
package aluPkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and sizes
    localparam int dataW     = 32;
    localparam int immW      = 24;
    localparam int opW       = 8;
    localparam int wbAddrW   = 2;
    localparam int flagW     = 4;
    localparam int fifoDepth = 4;      // Queued commands

    //////////////////////////////////////////////////////////////////////
    // Opcodes, same numbering as the CPU decoder
    localparam logic [opW-1:0] opAddIm = 8'd1;
    localparam logic [opW-1:0] opAdd   = 8'd3;
    localparam logic [opW-1:0] opAddC  = 8'd4;
    localparam logic [opW-1:0] opSubIm = 8'd5;
    localparam logic [opW-1:0] opSub   = 8'd7;
    localparam logic [opW-1:0] opSubC  = 8'd8;
    localparam logic [opW-1:0] opShl   = 8'd13;
    localparam logic [opW-1:0] opShr   = 8'd15;
    localparam logic [opW-1:0] opAnd   = 8'd17;
    localparam logic [opW-1:0] opNand  = 8'd18;
    localparam logic [opW-1:0] opOr    = 8'd19;
    localparam logic [opW-1:0] opNor   = 8'd20;
    localparam logic [opW-1:0] opXor   = 8'd21;
    localparam logic [opW-1:0] opXnor  = 8'd22;
    localparam logic [opW-1:0] opCp    = 8'd31;     // Unsigned compare
    localparam logic [opW-1:0] opSld   = 8'd46;     // Status load

    // Command port register map
    localparam logic [wbAddrW-1:0] addrOpA   = 2'd0;
    localparam logic [wbAddrW-1:0] addrOpB   = 2'd1;
    localparam logic [wbAddrW-1:0] addrCmd   = 2'd2;
    localparam logic [wbAddrW-1:0] addrFlags = 2'd3;

    // Status register bits
    localparam int flagCarry = 3;
    localparam int flagNeg   = 2;
    localparam int flagCmpHi = 1;
    localparam int flagCmpLo = 0;

    typedef logic [flagW-1:0] statusFlags;

    typedef struct packed {
        logic [opW-1:0]   opcode;
        logic [immW-1:0]  imm;
        logic [dataW-1:0] opA;
        logic [dataW-1:0] opB;
    } aluCmd;                          // 96 bits per queued entry

endpackage

// ==== tb.f ====
aluPkg.sv
aluCmdIntake.sv
aluCmdFifo.sv
aluExecute.sv
aluCore.sv
tbAlu_assertions.sv
tbAluChecker.sv
tbAluCore.sv

// ==== tbAluChecker.sv ====
`timescale 1ns/1ps

module tbAluChecker
(
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       cmdCyc,
    input  logic                       cmdStb,
    input  logic                       cmdWe,
    input  logic [aluPkg::wbAddrW-1:0] cmdAdr,
    input  logic [aluPkg::dataW-1:0]   cmdDatW,
    input  logic [aluPkg::dataW-1:0]   cmdDatR,
    input  logic                       cmdAck,
    input  logic                       resCyc,
    input  logic                       resStb,
    input  logic [aluPkg::dataW-1:0]   resDat,
    input  aluPkg::statusFlags         resFlags,
    input  logic                       resAck,
    output int                         errors,
    output int                         results,
    output int                         pending
);
    import aluPkg::*;

    logic [dataW-1:0] expDat [$];                       // Expected results, oldest first
    statusFlags       expFlags [$];
    logic [dataW-1:0] modelA;
    logic [dataW-1:0] modelB;
    statusFlags       modelFlags;
    logic [dataW-1:0] refDat;
    statusFlags       refFlags;
    logic [dataW-1:0] wantDat;
    statusFlags       wantFlags;
    logic             lastReq;
    logic             lastWe;
    logic [wbAddrW-1:0] lastAdr;
    logic [dataW-1:0] lastDat;

    //////////////////////////////////////////////////////////////////////
    // Reference model of one command
    function automatic logic refExec(input logic [opW-1:0] opc, input logic [immW-1:0] immv,
                                     input logic [dataW-1:0] x, input logic [dataW-1:0] y,
                                     input statusFlags fIn, output logic [dataW-1:0] res,
                                     output statusFlags fOut);
        logic [63:0] rhs;
        logic [63:0] wide;
        logic        kept;
        logic        setsNeg;
        kept    = 1'b1;
        setsNeg = 1'b1;
        res     = '0;
        fOut    = fIn;
        rhs     = (opc == opAddIm || opc == opSubIm) ? 64'(immv) : 64'(y);
        if (opc == opAddC || opc == opSubC)
        begin
            rhs = rhs + 64'(fIn[flagCarry]);            // Carry or borrow in
        end
        case (opc)
            opAddIm, opAdd, opAddC:
            begin
                wide            = 64'(x) + rhs;
                res             = wide[dataW-1:0];
                fOut[flagCarry] = wide[dataW];
            end
            opSubIm, opSub, opSubC:
            begin
                res             = x - rhs[dataW-1:0];
                fOut[flagCarry] = (64'(x) < rhs);       // Borrow out
            end
            opShl:  res = (immv >= 24'd32) ? '0 : x << immv[4:0];
            opShr:  res = (immv >= 24'd32) ? '0 : x >> immv[4:0];
            opAnd:  res = x & y;
            opNand: res = ~(x & y);
            opOr:   res = x | y;
            opNor:  res = ~(x | y);
            opXor:  res = x ^ y;
            opXnor: res = ~(x ^ y);
            opCp:
            begin
                setsNeg = 1'b0;
                {fOut[flagCmpHi], fOut[flagCmpLo]} = (x == y) ? 2'b11 : (x > y) ? 2'b10 : 2'b01;
            end
            opSld:
            begin
                setsNeg = 1'b0;
                res     = dataW'(fIn);
            end
            default:
            begin
                kept    = 1'b0;
                setsNeg = 1'b0;
            end
        endcase
        if (setsNeg)
        begin
            fOut[flagNeg] = res[dataW-1];
        end
        return kept;
    endfunction

    task automatic compareResult();
        if (expDat.size() == 0)
        begin
            $display("FAILED at %0t: result %h arrived with no command outstanding", $time, resDat);
            errors++;
        end
        else
        begin
            wantDat   = expDat.pop_front();
            wantFlags = expFlags.pop_front();
            if (resDat !== wantDat || resFlags !== wantFlags)
            begin
                $display("FAILED at %0t: result %h flags %b, expected %h flags %b",
                         $time, resDat, resFlags, wantDat, wantFlags);
                errors++;
            end
            results++;
        end
    endtask

    task automatic snoopAccess();
        if (lastWe)
        begin
            case (lastAdr)
                addrOpA: modelA = lastDat;
                addrOpB: modelB = lastDat;
                addrCmd:
                begin
                    if (refExec(lastDat[dataW-1 -: opW], lastDat[immW-1:0], modelA, modelB,
                                modelFlags, refDat, refFlags))
                    begin
                        expDat.push_back(refDat);
                        expFlags.push_back(refFlags);
                        modelFlags = refFlags;
                    end
                end
                default: ;
            endcase
        end
        else if (lastAdr == addrFlags && expDat.size() == 0 && cmdDatR !== dataW'(modelFlags))
        begin
            $display("FAILED at %0t: flag read %h, expected %h", $time, cmdDatR, modelFlags);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Snoop both ports on the rising edge
    always @(posedge clk)
    begin
        if (!rstN)
        begin
            modelFlags = '0;
            expDat.delete();
            expFlags.delete();
            lastReq = 1'b0;
        end
        else
        begin
            if (resCyc && resStb && resAck)
            begin
                compareResult();
            end
            if (cmdAck && lastReq)
            begin
                snoopAccess();                          // Request seen one edge earlier
            end
            lastReq = cmdCyc && cmdStb;
            lastWe  = cmdWe;
            lastAdr = cmdAdr;
            lastDat = cmdDatW;
        end
        pending = expDat.size();
    end

endmodule

// ==== tbAluCore.sv ====
`timescale 1ns/1ps

module tbAluCore;
    import aluPkg::*;

    localparam int          clkHalf      = 10;          // 20 ns period
    localparam int          resetCycles  = 3;
    localparam logic [15:0] lfsrSeed     = 16'd51241;
    localparam int          ackTimeout   = 50;
    localparam int          drainTimeout = 400;
    localparam int          stallProbe   = 12;

    localparam logic [opW-1:0] basicOps [12] = '{opAdd, opSub, opAddIm, opSubIm, opShl, opShr,
                                                 opAnd, opNand, opOr, opNor, opXor, opXnor};
    localparam logic [opW-1:0] unknownOps [6] = '{8'd0, 8'd2, 8'd6, 8'd9, 8'd40, 8'd255};

    logic               clk = 1'b0;
    logic               rstN;
    logic               cmdCyc;
    logic               cmdStb;
    logic               cmdWe;
    logic [wbAddrW-1:0] cmdAdr;
    logic [dataW-1:0]   cmdDatW;
    logic [dataW-1:0]   cmdDatR;
    logic               cmdAck;
    logic               resCyc;
    logic               resStb;
    logic               resWe;
    logic [dataW-1:0]   resDat;
    statusFlags         resFlags;
    logic               resAck = 1'b0;
    logic               holdAck;
    logic [15:0]        lfsr;
    logic [15:0]        stallLfsr = lfsrSeed;
    logic [1:0]         stallLeft = 2'd0;
    logic [opW-1:0]     op;
    logic [immW-1:0]    imm;
    logic [dataW-1:0]   a;
    logic [dataW-1:0]   b;
    logic               acked;
    int                 tbErrors;
    int                 timeouts;
    int                 keptIssued;
    int                 chkErrors;
    int                 results;
    int                 pending;
    int                 total;

    always #clkHalf clk = ~clk;

    aluCore dut (.*);

    tbAluChecker resChecker
    (
        .clk(clk), .rstN(rstN), .cmdCyc(cmdCyc), .cmdStb(cmdStb), .cmdWe(cmdWe),
        .cmdAdr(cmdAdr), .cmdDatW(cmdDatW), .cmdDatR(cmdDatR), .cmdAck(cmdAck),
        .resCyc(resCyc), .resStb(resStb), .resDat(resDat), .resFlags(resFlags),
        .resAck(resAck), .errors(chkErrors), .results(results), .pending(pending)
    );

    //////////////////////////////////////////////////////////////////////
    // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsrStep(lfsr);
        end
        return bits;
    endfunction

    // Result sink with a random stall of 0 to 3 cycles per result
    always @(negedge clk)
    begin
        if (resAck)
        begin
            resAck = 1'b0;
            for (int i = 0; i < 2; i++)
            begin
                stallLeft = {stallLeft[0], stallLfsr[0]};
                stallLfsr = lfsrStep(stallLfsr);
            end
        end
        else if (rstN && resStb && !holdAck)
        begin
            if (stallLeft == 2'd0)
            begin
                resAck = 1'b1;
            end
            else
            begin
                stallLeft = stallLeft - 2'd1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Command port host
    task automatic request(input logic we, input logic [wbAddrW-1:0] adr,
                           input logic [dataW-1:0] dat);
        cmdCyc  = 1'b1;
        cmdStb  = 1'b1;
        cmdWe   = we;
        cmdAdr  = adr;
        cmdDatW = dat;
    endtask

    task automatic waitAck(input int limit, output logic gotAck);
        int waited;
        waited = 0;
        gotAck = 1'b0;
        while (!gotAck && waited < limit)
        begin
            @(negedge clk);
            if (cmdAck)
            begin
                gotAck = 1'b1;
                cmdCyc = 1'b0;
                cmdStb = 1'b0;
                cmdWe  = 1'b0;
            end
            waited++;
        end
    endtask

    task automatic access(input logic we, input logic [wbAddrW-1:0] adr,
                          input logic [dataW-1:0] dat);
        logic gotAck;
        request(we, adr, dat);
        waitAck(ackTimeout, gotAck);
        if (!gotAck)
        begin
            $display("Timeout: no cmdAck for address %0d within %0d cycles at %0t",
                     adr, ackTimeout, $time);
            timeouts++;
        end
    endtask

    task automatic issueCmd(input logic [opW-1:0] opc, input logic [immW-1:0] immv,
                            input logic [dataW-1:0] x, input logic [dataW-1:0] y, input logic kept);
        access(1'b1, addrOpA, x);
        access(1'b1, addrOpB, y);
        access(1'b1, addrCmd, {opc, immv});
        if (kept)
        begin
            keptIssued++;
        end
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        @(negedge clk);                                 // Let the checker see the last command
        while ((pending != 0 || resStb) && waited < drainTimeout)
        begin
            @(negedge clk);
            waited++;
        end
        if (pending != 0 || resStb)
        begin
            $display("Timeout: %0d results still outstanding at %0t", pending, $time);
            timeouts++;
        end
    endtask

    initial
    begin
        rstN    = 1'b0;
        cmdCyc  = 1'b0;
        cmdStb  = 1'b0;
        cmdWe   = 1'b0;
        cmdAdr  = '0;
        cmdDatW = '0;
        holdAck = 1'b0;
        lfsr    = lfsrSeed;
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;

        // Idle after reset and flags read as zero
        if (cmdAck || resCyc || resStb)
        begin
            $display("FAILED at %0t: control outputs not low after reset", $time);
            tbErrors++;
        end
        access(1'b0, addrFlags, '0);

        // Random arithmetic, shift and logic commands
        for (int n = 0; n < 24; n++)
        begin
            op  = basicOps[randBits(4) % 12];
            imm = (op == opShl || op == opShr) ? 24'(randBits(6)) : 24'(randBits(24));
            a   = randBits(32);
            b   = randBits(32);
            issueCmd(op, imm, a, b, 1'b1);
        end
        waitDrain();

        // Carry and borrow chains
        for (int n = 0; n < 6; n++)
        begin
            issueCmd(opAdd, '0, randBits(32), randBits(32), 1'b1);
            issueCmd(opAddC, '0, randBits(32), randBits(32), 1'b1);
            issueCmd(opSub, '0, randBits(32), randBits(32), 1'b1);
            issueCmd(opSubC, '0, randBits(32), randBits(32), 1'b1);
        end
        waitDrain();

        // Compare equal, greater and less with a status load and flag read after each
        for (int n = 0; n < 3; n++)
        begin
            a = randBits(31) | 32'h1;
            b = (n == 0) ? a : (n == 1) ? a - 32'd1 : a + 32'd1;
            issueCmd(opCp, '0, a, b, 1'b1);
            issueCmd(opSld, '0, a, b, 1'b1);
            waitDrain();
            access(1'b0, addrFlags, '0);
        end

        //////////////////////////////////////////////////////////////////////
        // Back-pressure with one command in execute plus a full queue
        holdAck = 1'b1;
        for (int n = 0; n <= fifoDepth; n++)
        begin
            issueCmd(opXor, '0, randBits(32), randBits(32), 1'b1);
        end
        request(1'b1, addrCmd, {opAdd, 24'd0});
        waitAck(stallProbe, acked);
        if (acked)
        begin
            $display("FAILED at %0t: command accepted while the queue was full", $time);
            tbErrors++;
        end
        holdAck = 1'b0;
        waitAck(ackTimeout, acked);
        if (!acked)
        begin
            $display("Timeout: stalled command not accepted after release at %0t", $time);
            timeouts++;
        end
        keptIssued++;
        waitDrain();

        // Unknown opcodes mixed into the stream
        for (int n = 0; n < 16; n++)
        begin
            a = randBits(32);
            b = randBits(32);
            if (randBits(1) == 32'd1)
            begin
                issueCmd(basicOps[randBits(4) % 12], 24'(randBits(5)), a, b, 1'b1);
            end
            else
            begin
                issueCmd(unknownOps[randBits(3) % 6], 24'(randBits(24)), a, b, 1'b0);
            end
        end
        issueCmd(8'd255, '0, '0, '0, 1'b0);
        waitDrain();
        access(1'b0, addrFlags, '0);

        if (results != keptIssued)
        begin
            $display("FAILED at %0t: %0d results for %0d kept commands",
                     $time, results, keptIssued);
            tbErrors++;
        end
        total = tbErrors + chkErrors + timeouts + dut.protocolChecks.failures;
        $display("Summary: %0d results, %0d checker, %0d tb, %0d timeout, %0d assertion errors",
                 results, chkErrors, tbErrors, timeouts, dut.protocolChecks.failures);
        if (total == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== tbAlu_assertions.sv ====
`timescale 1ns/1ps

module tbAlu_assertions
(
    input logic                       clk,
    input logic                       rstN,
    input logic                       cmdCyc,
    input logic                       cmdStb,
    input logic                       cmdAck,
    input logic                       resCyc,
    input logic                       resStb,
    input logic                       resWe,
    input logic [aluPkg::dataW-1:0]   resDat,
    input aluPkg::statusFlags         resFlags,
    input logic                       resAck
);
    int failures = 0;

    cmdAckAfterReq: assert property (@(posedge clk) disable iff (!rstN)
        cmdAck |-> $past(cmdCyc && cmdStb))
        else begin failures++; $error("cmdAck without a pending request"); end

    resAckAfterReq: assert property (@(posedge clk) disable iff (!rstN)
        resAck |-> (resCyc && resStb))
        else begin failures++; $error("resAck outside a result cycle"); end

    resHeldUntilAck: assert property (@(posedge clk) disable iff (!rstN)
        (resStb && !resAck) |=> (resCyc && resStb && $stable(resDat) && $stable(resFlags)))
        else begin failures++; $error("Result signals changed before resAck"); end

    resWriteOnly: assert property (@(posedge clk) disable iff (!rstN)
        resStb |-> resWe)
        else begin failures++; $error("resWe low while resStb is high"); end

    // Outputs clear one edge after the synchronous reset
    idleInReset: assert property (@(posedge clk)
        !rstN |=> (!cmdAck && !resCyc && !resStb && !resWe))
        else begin failures++; $error("Control outputs active during reset"); end

endmodule

bind aluCore tbAlu_assertions protocolChecks
(
    .clk      (clk),
    .rstN     (rstN),
    .cmdCyc   (cmdCyc),
    .cmdStb   (cmdStb),
    .cmdAck   (cmdAck),
    .resCyc   (resCyc),
    .resStb   (resStb),
    .resWe    (resWe),
    .resDat   (resDat),
    .resFlags (resFlags),
    .resAck   (resAck)
);
